// File: nes_cart_pkg.sv
/*
 * NES cartridge loader definitions
 * iNES header constants, cartridge address map, mapper flag word and loader states
 */
`default_nettype none

package nes_cart_pkg;

	typedef logic [21:0] cart_addr_t;   // Byte address in cartridge memory
	typedef logic [7:0]  cart_byte_t;

	// Flag word handed to the console mapper logic
	typedef struct packed {
		logic [6:0] reserved;
		logic [7:0] submapper;      // iNES 2.0 byte 8, zero otherwise
		logic       four_screen;
		logic       has_chr_ram;
		logic       mirroring;
		logic [2:0] chr_size;       // log2 of 8 KiB pages
		logic [2:0] prg_size;       // log2 of 16 KiB pages
		logic [7:0] mapper;
	} mapper_flags_t;

	typedef enum logic [2:0] {
		load_header,
		load_prg,
		load_chr,
		load_done,
		load_error
	} load_state_t;

	// iNES header
	localparam int         INES_HDR_BYTES = 16;
	localparam cart_byte_t INES_MAGIC0    = 8'h4E;  // 'N'
	localparam cart_byte_t INES_MAGIC1    = 8'h45;  // 'E'
	localparam cart_byte_t INES_MAGIC2    = 8'h53;  // 'S'
	localparam cart_byte_t INES_MAGIC3    = 8'h1A;

	// PRG pages are 16 KiB, CHR pages 8 KiB
	localparam int PRG_PAGE_SHIFT = 14;
	localparam int CHR_PAGE_SHIFT = 13;

	// Cartridge memory map
	localparam cart_addr_t PRG_BASE = 22'h000000;
	localparam cart_addr_t CHR_BASE = 22'h200000;

	localparam logic [7:0] DL_RESET_COUNT = 8'd255;  // Settle cycles after a download

	// Four-player adapter signature, shifted out after the second pad
	localparam cart_byte_t MULTITAP_SIG_P1 = 8'h08;
	localparam cart_byte_t MULTITAP_SIG_P2 = 8'h04;
	localparam int         PAD_BITS        = 24;

endpackage

`default_nettype wire

// File: cart_write_if.sv
/*
 * Cartridge write channel
 * One byte write from the ROM loader to the memory write port
 */
`timescale 1ns/1ps
`default_nettype none

interface cart_write_if;
	import nes_cart_pkg::*;

	cart_addr_t addr;
	cart_byte_t data;
	logic       strobe;    // One-cycle request, only while busy is low
	logic       busy;      // A write is still in flight

	modport loader (output addr, output data, output strobe, input busy);
	modport port (input addr, input data, input strobe, output busy);

endinterface

`default_nettype wire

// File: ines_header_decode.sv
/*
 * iNES header decoder
 * Stores the 16 header bytes, checks the signature and builds the mapper flag word
 */
`timescale 1ns/1ps
`default_nettype none

module ines_header_decode (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        hdr_we,
	input  logic [3:0]                  hdr_index,
	input  nes_cart_pkg::cart_byte_t    hdr_byte,
	input  logic                        invert_mirroring,
	output logic                        hdr_valid,
	output nes_cart_pkg::cart_byte_t    prg_pages,
	output nes_cart_pkg::cart_byte_t    chr_pages,
	output nes_cart_pkg::mapper_flags_t flags
);
	import nes_cart_pkg::*;

	cart_byte_t hdr [INES_HDR_BYTES];
	logic       is_nes20;
	logic       is_dirty;

	// Ceiling of log2, count 0 treated as 1, saturating at 7
	function automatic logic [2:0] size_code(input cart_byte_t pages);
		logic [2:0] code;
		code = 3'd0;
		for (int i = 0; i < 7; i++) begin
			if (pages > (cart_byte_t'(1) << i))
				code = 3'(i + 1);
		end
		return code;
	endfunction

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < INES_HDR_BYTES; i++)
				hdr[i] <= '0;
		end else if (hdr_we) begin
			hdr[hdr_index] <= hdr_byte;
		end
	end

	// Trainers are not supported
	assign hdr_valid = (hdr[0] == INES_MAGIC0) && (hdr[1] == INES_MAGIC1) &&
		(hdr[2] == INES_MAGIC2) && (hdr[3] == INES_MAGIC3) && !hdr[6][2];

	assign prg_pages = hdr[4];
	assign chr_pages = hdr[5];

	assign is_nes20 = (hdr[7][3:2] == 2'b10);

	// Old dumps often carry junk in the tail of an iNES 1.0 header
	assign is_dirty = !is_nes20 && ((hdr[9][7:1] != '0) ||
		(|{hdr[10], hdr[11], hdr[12], hdr[13], hdr[14], hdr[15]}));

	always_comb begin
		flags.reserved    = '0;
		flags.submapper   = is_nes20 ? hdr[8] : 8'h00;
		flags.four_screen = hdr[6][3];
		flags.has_chr_ram = (chr_pages == '0);
		flags.mirroring   = hdr[6][0] ^ invert_mirroring;
		flags.chr_size    = size_code(chr_pages);
		flags.prg_size    = size_code(prg_pages);
		flags.mapper      = {is_dirty ? 4'h0 : hdr[7][7:4], hdr[6][7:4]};
	end

endmodule

`default_nettype wire

// File: rom_load_fsm.sv
/*
 * ROM loader FSM
 * Walks the iNES header, PRG and CHR sections of the download and
 * issues one cartridge write per accepted byte
 */
`timescale 1ns/1ps
`default_nettype none

module rom_load_fsm (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        dl_active,
	input  logic                        dl_valid,
	input  nes_cart_pkg::cart_byte_t    dl_data,
	input  logic                        invert_mirroring,
	cart_write_if.loader                wr,
	output logic                        busy,
	output logic                        done,
	output logic                        error,
	output nes_cart_pkg::mapper_flags_t mapper_flags
);
	import nes_cart_pkg::*;

	load_state_t   state;
	logic [3:0]    hdr_count;
	cart_addr_t    wr_addr;
	cart_addr_t    bytes_left;
	logic          in_rom;
	logic          take_byte;
	logic          finish;
	logic          hdr_valid;
	cart_byte_t    prg_pages;
	cart_byte_t    chr_pages;
	mapper_flags_t hdr_flags;

	ines_header_decode ines_header_decode_inst (
		.clk              (clk),
		.reset            (reset),
		.hdr_we           (take_byte && (state == load_header)),
		.hdr_index        (hdr_count),
		.hdr_byte         (dl_data),
		.invert_mirroring (invert_mirroring),
		.hdr_valid        (hdr_valid),
		.prg_pages        (prg_pages),
		.chr_pages        (chr_pages),
		.flags            (hdr_flags)
	);

	assign in_rom = (state == load_prg) || (state == load_chr);

	// A byte is only taken while the write port is free
	assign take_byte = dl_active && dl_valid && !wr.busy &&
		((state == load_header) || (in_rom && (bytes_left != '0)));

	// Section exhausted and nothing more to fetch
	assign finish = in_rom && (bytes_left == '0) &&
		!((state == load_prg) && (chr_pages != '0));

	assign wr.addr   = wr_addr;
	assign wr.data   = dl_data;
	assign wr.strobe = take_byte;

	always_ff @(posedge clk) begin
		if (reset) begin
			state      <= load_header;
			hdr_count  <= '0;
			wr_addr    <= '0;
			bytes_left <= '0;
			busy       <= 1'b0;
			done       <= 1'b0;
			error      <= 1'b0;
		end else begin
			case (state)
				load_header: if (take_byte) begin
					hdr_count <= hdr_count + 4'd1;
					wr_addr   <= wr_addr + cart_addr_t'(1);
					if (hdr_count == 4'(INES_HDR_BYTES - 1)) begin
						if (hdr_valid) begin
							state      <= load_prg;
							wr_addr    <= PRG_BASE;
							bytes_left <= cart_addr_t'(prg_pages) << PRG_PAGE_SHIFT;
							busy       <= 1'b1;
						end else begin
							state <= load_error;
							error <= 1'b1;
						end
					end
				end
				load_prg, load_chr: begin
					if (bytes_left != '0) begin
						if (take_byte) begin
							bytes_left <= bytes_left - cart_addr_t'(1);
							wr_addr    <= wr_addr + cart_addr_t'(1);
						end
					end else if (!finish) begin
						state      <= load_chr;     // CHR RAM carts skip this
						wr_addr    <= CHR_BASE;
						bytes_left <= cart_addr_t'(chr_pages) << CHR_PAGE_SHIFT;
					end else begin
						state <= load_done;
						done  <= 1'b1;
						busy  <= 1'b0;
					end
				end
				default: ;                          // Done and error hold until restart
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (finish)
			mapper_flags <= hdr_flags;
	end

endmodule

`default_nettype wire

// File: cart_write_port.sv
/*
 * Cartridge memory write port
 * Captures one loader write and completes it with a four-phase req/ack handshake
 */
`timescale 1ns/1ps
`default_nettype none

module cart_write_port (
	input  logic                     clk,
	input  logic                     reset,
	cart_write_if.port               wr,
	output logic                     mem_req,
	output nes_cart_pkg::cart_addr_t mem_addr,
	output nes_cart_pkg::cart_byte_t mem_data,
	input  logic                     mem_ack
);

	typedef enum logic [1:0] {
		port_idle,
		port_req,       // Request raised, waiting for ack
		port_release    // Request dropped, waiting for ack to fall
	} port_state_t;

	port_state_t state;

	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= port_idle;
			mem_req <= 1'b0;
		end else begin
			case (state)
				port_idle: if (wr.strobe) state <= port_req;
				port_req: begin
					if (mem_ack) begin
						state   <= port_release;
						mem_req <= 1'b0;
					end else begin
						mem_req <= 1'b1;    // Address and data settled one cycle earlier
					end
				end
				port_release: if (!mem_ack) state <= port_idle;
				default: state <= port_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (wr.strobe && (state == port_idle)) begin
			mem_addr <= wr.addr;
			mem_data <= wr.data;
		end
	end

	assign wr.busy = (state != port_idle);

endmodule

`default_nettype wire

// File: joypad_serializer.sv
/*
 * Joypad serializer
 * Two NES controller shift registers with port swap and four-player adapter support
 */
`timescale 1ns/1ps
`default_nettype none

module joypad_serializer (
	input  logic       clk,
	input  logic       reset,
	input  logic [7:0] joy_a,
	input  logic [7:0] joy_b,
	input  logic [7:0] joy_c,
	input  logic [7:0] joy_d,
	input  logic       joy_swap,
	input  logic       multitap,
	input  logic       pad_strobe,
	input  logic [1:0] pad_clock,
	output logic [1:0] pad_data
);
	import nes_cart_pkg::*;

	logic [7:0]                nes_a;
	logic [7:0]                nes_b;
	logic [7:0]                nes_c;
	logic [7:0]                nes_d;
	logic [1:0][PAD_BITS-1:0] load_val;
	logic [1:0][PAD_BITS-1:0] pad_sr;
	logic [1:0]                clock_q;

	// Host order R,L,D,U,A,B,Sel,Start to NES shift order A,B,Sel,Start,U,D,L,R
	function automatic logic [7:0] nes_order(input logic [7:0] joy);
		return {joy[0], joy[1], joy[2], joy[3], joy[7], joy[6], joy[5], joy[4]};
	endfunction

	assign nes_a = nes_order(joy_a);
	assign nes_b = nes_order(joy_b);
	assign nes_c = nes_order(joy_c);
	assign nes_d = nes_order(joy_d);

	// Pads 3 and 4 and the adapter signature follow the first byte
	assign load_val[0] = {multitap ? {MULTITAP_SIG_P1, nes_c} : 16'h0000,
		joy_swap ? nes_b : nes_a};
	assign load_val[1] = {multitap ? {MULTITAP_SIG_P2, nes_d} : 16'h0000,
		joy_swap ? nes_a : nes_b};

	always_ff @(posedge clk) begin
		if (reset) begin
			pad_sr  <= '0;
			clock_q <= '0;
		end else begin
			for (int p = 0; p < 2; p++) begin
				if (pad_strobe)
					pad_sr[p] <= load_val[p];
				else if (clock_q[p] && !pad_clock[p])   // Falling pad clock
					pad_sr[p] <= {1'b0, pad_sr[p][PAD_BITS-1:1]};
			end
			clock_q <= pad_clock;
		end
	end

	assign pad_data = {pad_sr[1][0], pad_sr[0][0]};

endmodule

`default_nettype wire

// File: reset_sequencer.sv
/*
 * Console reset sequencer
 * Holds the console in reset until the first download, through each download
 * and its settle window, and while a load has failed
 */
`timescale 1ns/1ps
`default_nettype none

module reset_sequencer (
	input  logic clk,
	input  logic reset,
	input  logic dl_active,
	input  logic loader_busy,
	input  logic load_error,
	output logic nes_reset,
	output logic loader_reset
);
	import nes_cart_pkg::*;

	logic       init_released;
	logic       dl_active_q;
	logic [7:0] settle_cnt;

	always_ff @(posedge clk) begin
		if (reset) begin
			init_released <= 1'b0;
			dl_active_q   <= 1'b0;
			settle_cnt    <= '0;
		end else begin
			dl_active_q <= dl_active;
			if (dl_active)
				init_released <= 1'b1;
			if (dl_active)
				settle_cnt <= DL_RESET_COUNT;
			else if ((settle_cnt != '0) && !loader_busy && !load_error)
				settle_cnt <= settle_cnt - 8'd1;    // A failed load keeps the window open
		end
	end

	assign nes_reset = !init_released || dl_active || (settle_cnt != '0) || load_error;

	// Idle loader stays in reset, a download inside a settle window restarts it
	assign loader_reset = (settle_cnt == '0) ? !dl_active : (dl_active && !dl_active_q);

endmodule

`default_nettype wire

// File: nes_cart_top.sv
/*
 * NES cartridge front end
 * iNES loader with four-phase memory writes, console reset sequencing
 * and the two-port joypad serializer
 */
`timescale 1ns/1ps
`default_nettype none

module nes_cart_top (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        dl_active,
	input  logic                        dl_valid,
	input  nes_cart_pkg::cart_byte_t    dl_data,
	output logic                        dl_wait,
	input  logic                        invert_mirroring,
	output logic                        mem_req,
	output nes_cart_pkg::cart_addr_t    mem_addr,
	output nes_cart_pkg::cart_byte_t    mem_data,
	input  logic                        mem_ack,
	output logic                        load_busy,
	output logic                        load_done,
	output logic                        load_error,
	output nes_cart_pkg::mapper_flags_t mapper_flags,
	output logic                        nes_reset,
	input  logic [7:0]                  joy_a,
	input  logic [7:0]                  joy_b,
	input  logic [7:0]                  joy_c,
	input  logic [7:0]                  joy_d,
	input  logic                        joy_swap,
	input  logic                        multitap,
	input  logic                        pad_strobe,
	input  logic [1:0]                  pad_clock,
	output logic [1:0]                  pad_data
);

	logic loader_reset;

	cart_write_if wr_if ();

	reset_sequencer reset_sequencer_inst (
		.clk          (clk),
		.reset        (reset),
		.dl_active    (dl_active),
		.loader_busy  (load_busy),
		.load_error   (load_error),
		.nes_reset    (nes_reset),
		.loader_reset (loader_reset)
	);

	rom_load_fsm rom_load_fsm_inst (
		.clk              (clk),
		.reset            (loader_reset),
		.dl_active        (dl_active),
		.dl_valid         (dl_valid),
		.dl_data          (dl_data),
		.invert_mirroring (invert_mirroring),
		.wr               (wr_if.loader),
		.busy             (load_busy),
		.done             (load_done),
		.error            (load_error),
		.mapper_flags     (mapper_flags)
	);

	cart_write_port cart_write_port_inst (
		.clk      (clk),
		.reset    (reset),
		.wr       (wr_if.port),
		.mem_req  (mem_req),
		.mem_addr (mem_addr),
		.mem_data (mem_data),
		.mem_ack  (mem_ack)
	);

	// Downloader stalls for as long as a write is outstanding
	assign dl_wait = wr_if.busy;

	joypad_serializer joypad_serializer_inst (
		.clk        (clk),
		.reset      (reset),
		.joy_a      (joy_a),
		.joy_b      (joy_b),
		.joy_c      (joy_c),
		.joy_d      (joy_d),
		.joy_swap   (joy_swap),
		.multitap   (multitap),
		.pad_strobe (pad_strobe),
		.pad_clock  (pad_clock),
		.pad_data   (pad_data)
	);

endmodule

`default_nettype wire

// File: tb_nes_cart.sv
/*
 * Testbench for the NES cartridge front end
 * Table-driven iNES loads against a req/ack memory model, reset sequencing and joypad readout
 */
`timescale 1ns/1ps
`default_nettype none

module tb_nes_cart;

	typedef struct packed {
		logic [31:0] sig;      // Header bytes 0 to 3
		logic [7:0]  b6;
		logic [7:0]  b7;
		logic [7:0]  b8;
		logic [7:0]  b12;      // Tail byte, junk in a dirty header
		logic [7:0]  prg;
		logic [7:0]  chr;
		logic        inv;
		logic        valid;
		logic [31:0] flags;
		logic [31:0] joys;     // Pads a, b, c, d from the top byte down
		logic        swap;
		logic        mt;
		logic        stall;    // Memory holds off ack on each 4 KiB boundary
	} case_row_t;

	logic        clk;
	logic        reset;
	logic        dl_active, dl_valid, dl_wait, invert_mirroring;
	logic [7:0]  dl_data;
	logic        mem_req, mem_ack;
	logic [21:0] mem_addr;
	logic [7:0]  mem_data;
	logic        load_busy, load_done, load_error, nes_reset;
	logic [31:0] mapper_flags;
	logic [7:0]  joy_a, joy_b, joy_c, joy_d;
	logic        joy_swap, multitap, pad_strobe;
	logic [1:0]  pad_clock, pad_data;

	case_row_t   rows [7];
	logic [15:0] lfsr;
	logic [7:0]  mem_bytes [logic [21:0]];    // Last byte written per address
	int          mem_cnt [logic [21:0]];
	logic [7:0]  payload [$];
	int          errors, checks, drops;
	logic        stall_mode;

	nes_cart_top nes_cart_top_inst (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// x^16 + x^14 + x^13 + x^11, one step per bit taken
	function automatic logic [7:0] lfsr_bits(input int n);
		logic [7:0] v;
		logic       fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], fb};
			v    = {v[6:0], fb};
		end
		return v;
	endfunction

	// Serial bit i of a port in A,B,Select,Start,Up,Down,Left,Right order, then pad 3/4 and signature
	function automatic logic pad_bit(input int port, input int i, input case_row_t c);
		logic [7:0] own;
		logic [7:0] tap;
		logic [7:0] sig;
		int         k;
		own = ((port == 0) ^ c.swap) ? c.joys[31:24] : c.joys[23:16];
		tap = (port == 0) ? c.joys[15:8] : c.joys[7:0];
		sig = (port == 0) ? 8'h08 : 8'h04;
		k   = ((i % 8) < 4) ? (i % 8) + 4 : 7 - (i % 8);    // Host bit for this slot
		if (i < 8)
			return own[k];
		if (!c.mt)
			return 1'b0;
		if (i < 16)
			return tap[k];
		return sig[i - 16];
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("sim failed");
		$finish;
	endtask

	task automatic send_byte(input logic [7:0] b);
		int t;
		t = 0;
		@(negedge clk);
		while (dl_wait) begin
			t++;
			if (t > 200)
				abort_run("downloader held off by dl_wait for more than 200 cycles");
			@(negedge clk);
		end
		@(posedge clk);
		dl_valid <= 1'b1;
		dl_data  <= b;
		@(posedge clk);
		dl_valid <= 1'b0;
	endtask

	task automatic load_case(input case_row_t c);
		logic [7:0]  hdr [16];
		logic [21:0] a;
		int          prg_bytes, chr_bytes, t, exp_n;
		hdr = '{c.sig[31:24], c.sig[23:16], c.sig[15:8], c.sig[7:0], c.prg, c.chr, c.b6, c.b7,
			c.b8, 8'h00, 8'h00, 8'h00, c.b12, 8'h00, 8'h00, 8'h00};
		prg_bytes = int'(c.prg) << 14;
		chr_bytes = int'(c.chr) << 13;
		mem_bytes.delete();
		mem_cnt.delete();
		payload.delete();
		stall_mode = c.stall;
		drops = 0;
		@(posedge clk);
		invert_mirroring <= c.inv;
		dl_active        <= 1'b1;
		repeat (2) @(posedge clk);
		for (int i = 0; i < 16; i++)
			send_byte(hdr[i]);
		if (c.valid) begin
			@(negedge clk);
			checks++;
			if (load_busy !== 1'b1) begin
				errors++;
				$display("[FAIL] load_busy got %h exp %h", load_busy, 1'b1);
			end
			for (int i = 0; i < prg_bytes + chr_bytes; i++) begin
				payload.push_back(lfsr_bits(8));
				send_byte(payload[i]);
			end
		end
		t = 0;
		@(negedge clk);
		while (!(c.valid ? load_done : load_error)) begin
			t++;
			if (t > 2)
				abort_run("load did not end within 2 cycles of the last byte");
			@(negedge clk);
		end
		t = 0;
		while (dl_wait || mem_req) begin    // Let the last write drain
			t++;
			if (t > 200)
				abort_run("write port did not go idle after the load");
			@(negedge clk);
		end
		checks += 3;
		if (load_done !== c.valid) begin
			errors++;
			$display("[FAIL] load_done got %h exp %h", load_done, c.valid);
		end
		if (load_error !== !c.valid) begin
			errors++;
			$display("[FAIL] load_error got %h exp %h", load_error, !c.valid);
		end
		if (load_busy !== 1'b0) begin
			errors++;
			$display("[FAIL] load_busy got %h exp %h", load_busy, 1'b0);
		end
		if (c.valid) begin
			checks++;
			if (mapper_flags !== c.flags) begin
				errors++;
				$display("[FAIL] mapper_flags got %h exp %h", mapper_flags, c.flags);
			end
			for (int i = 0; i < prg_bytes + chr_bytes; i++) begin
				a = (i < prg_bytes) ? 22'(i) : 22'h200000 + 22'(i - prg_bytes);
				exp_n = (i < 16) ? 2 : 1;    // Header shares the start of PRG
				checks++;
				if (!mem_cnt.exists(a)) begin
					errors++;
					$display("No write reached address %h", a);
				end else if (mem_cnt[a] != exp_n) begin
					errors++;
					$display("Address %h written %0d times, expected %0d", a, mem_cnt[a], exp_n);
				end else if (mem_bytes[a] !== payload[i]) begin
					errors++;
					$display("[FAIL] mem_data at %h got %h exp %h", a, mem_bytes[a], payload[i]);
				end
			end
			checks++;
			if (mem_cnt.num() != prg_bytes + chr_bytes) begin
				errors++;
				$display("Writes landed on %0d addresses, expected %0d", mem_cnt.num(),
					prg_bytes + chr_bytes);
			end
		end else begin
			foreach (mem_cnt[k]) begin
				checks++;
				if (k > 22'd15) begin
					errors++;
					$display("Rejected file wrote past the header, address %h", k);
				end
			end
		end
		checks++;
		if (drops != 0) begin
			errors++;
			$display("Console left reset during the download");
		end
		@(posedge clk);
		dl_active <= 1'b0;
		t = 0;
		@(negedge clk);
		while (nes_reset && t <= 300) begin
			t++;
			@(negedge clk);
		end
		checks++;
		if (c.valid && (t < 255 || t > 300)) begin
			errors++;
			$display("Console reset released %0d cycles after the download", t);
		end else if (!c.valid && (t <= 300 || !load_error)) begin
			errors++;
			$display("Console reset or load error released after a failed load");
		end
	endtask

	task automatic read_pads(input case_row_t c);
		logic [1:0] exp;
		@(posedge clk);
		joy_a      <= c.joys[31:24];
		joy_b      <= c.joys[23:16];
		joy_c      <= c.joys[15:8];
		joy_d      <= c.joys[7:0];
		joy_swap   <= c.swap;
		multitap   <= c.mt;
		pad_strobe <= 1'b1;
		@(posedge clk);
		pad_strobe <= 1'b0;
		for (int i = 0; i < 24; i++) begin
			@(negedge clk);
			exp = {pad_bit(1, i, c), pad_bit(0, i, c)};
			checks++;
			if (pad_data !== exp) begin
				errors++;
				$display("[FAIL] pad_data bit %0d got %h exp %h", i, pad_data, exp);
			end
			@(posedge clk);
			pad_clock <= 2'b11;
			@(posedge clk);
			pad_clock <= 2'b00;
			@(posedge clk);                 // Shift lands on this edge
		end
	endtask

	initial begin : reset_monitor
		forever begin
			@(negedge clk);
			if (dl_active && !nes_reset)
				drops++;
		end
	end

	// Memory model for the four-phase write port
	initial begin : mem_responder
		int hold;
		int t;
		forever begin
			@(negedge clk);
			if (mem_req) begin
				if (mem_cnt.exists(mem_addr))
					mem_cnt[mem_addr]++;
				else
					mem_cnt[mem_addr] = 1;
				mem_bytes[mem_addr] = mem_data;
				hold = (stall_mode && mem_addr[11:0] == 12'h000) ? 50 : int'(lfsr_bits(2));
				repeat (hold) begin
					@(negedge clk);
					if (stall_mode && !dl_wait) begin
						errors++;
						$display("[FAIL] dl_wait got %h exp %h during a held ack", dl_wait, 1'b1);
					end
				end
				@(posedge clk);
				mem_ack <= 1'b1;
				t = 0;
				@(negedge clk);
				while (mem_req) begin
					t++;
					if (t > 20)
						abort_run("mem_req stayed high after mem_ack");
					@(negedge clk);
				end
				@(posedge clk);
				mem_ack <= 1'b0;
			end
		end
	end

	initial begin : main_flow
		int start_err;
		lfsr       = 16'd33;
		errors     = 0;
		checks     = 0;
		drops      = 0;
		stall_mode = 1'b0;
		reset      = 1'b1;
		dl_active  = 1'b0;
		dl_valid   = 1'b0;
		dl_data    = 8'h00;
		invert_mirroring = 1'b0;
		mem_ack    = 1'b0;
		{joy_a, joy_b, joy_c, joy_d} = 32'h0;
		{joy_swap, multitap, pad_strobe} = 3'b000;
		pad_clock  = 2'b00;
		// Clean 1.0, bad signature, dirty 1.0, trainer, 2.0 with CHR RAM, inverted, stalled
		rows[0] = '{32'h4E45531A, 8'h11, 8'h00, 8'h00, 8'h00, 8'd1, 8'd1, 1'b0, 1'b1,
			32'h0000_4001, 32'h8142_A55A, 1'b0, 1'b0, 1'b0};
		rows[1] = '{32'h4E45531B, 8'h11, 8'h00, 8'h00, 8'h00, 8'd1, 8'd1, 1'b0, 1'b0,
			32'h0, 32'h0FF0_33CC, 1'b0, 1'b1, 1'b0};
		rows[2] = '{32'h4E45531A, 8'h40, 8'h30, 8'h00, 8'h44, 8'd2, 8'd1, 1'b0, 1'b1,
			32'h0000_0104, 32'h0180_7EE7, 1'b1, 1'b0, 1'b0};
		rows[3] = '{32'h4E45531A, 8'h04, 8'h00, 8'h00, 8'h00, 8'd1, 8'd1, 1'b0, 1'b0,
			32'h0, 32'hFF00_5AA5, 1'b1, 1'b1, 1'b0};
		rows[4] = '{32'h4E45531A, 8'h21, 8'h18, 8'h35, 8'h07, 8'd1, 8'd0, 1'b0, 1'b1,
			32'h006A_C012, 32'h1020_4080, 1'b0, 1'b1, 1'b0};
		rows[5] = '{32'h4E45531A, 8'h08, 8'h70, 8'h00, 8'h00, 8'd5, 8'd2, 1'b1, 1'b1,
			32'h0001_4B70, 32'hC33C_9669, 1'b1, 1'b1, 1'b0};
		rows[6] = '{32'h4E45531A, 8'h11, 8'h00, 8'h00, 8'h00, 8'd1, 8'd1, 1'b0, 1'b1,
			32'h0000_4001, 32'h00FF_00FF, 1'b0, 1'b0, 1'b1};
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		start_err = errors;
		repeat (20) begin                   // Console held until the first download
			@(negedge clk);
			checks++;
			if ({mem_req, dl_wait, load_busy, load_done, load_error, nes_reset} !== 6'b000001) begin
				errors++;
				$display("[FAIL] {mem_req,dl_wait,load_busy,load_done,load_error,nes_reset} got %h exp %h",
					{mem_req, dl_wait, load_busy, load_done, load_error, nes_reset}, 6'b000001);
			end
		end
		$display("reset: %0s", (errors == start_err) ? "ok" : "FAILED");
		for (int r = 0; r < $size(rows); r++) begin
			start_err = errors;
			load_case(rows[r]);
			read_pads(rows[r]);
			$display("case %0d: %0s", r, (errors == start_err) ? "ok" : "FAILED");
		end
		$display("%0d cases, %0d checks, %0d errors", $size(rows), checks, errors);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
nes_cart_pkg.sv
cart_write_if.sv
ines_header_decode.sv
rom_load_fsm.sv
cart_write_port.sv
joypad_serializer.sv
reset_sequencer.sv
nes_cart_top.sv
tb_nes_cart.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and judge the result from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -j 0 --top-module tb_nes_cart -f filelist.f -o sim_nes_cart \
	> build.log 2>&1 || { cat build.log; echo "BUILD FAILED"; exit 1; }
./obj_dir/sim_nes_cart > sim.log 2>&1
cat sim.log
grep -qx "sim passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
